//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/rv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types, enums and constants for the single-cycle rv32i core
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package rv_pkg;

    localparam int xlen  = 32;
    localparam int nregs = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t reset_pc = 32'h8000_0000;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load/store width funct3, stores share the signed codes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [6:0] funct7_sub = 7'b0100000;  // sub / sra marker

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_other  = 7'b0000000   // anything unsupported
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } inst_fmt_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        inst_fmt_e  fmt;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        alu_op_e    alu_op;
    } dec_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] wmask;   // byte lanes
        logic       wen;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- hw/core_top.sv
////////////////////////////////////////////////////////////////////////////
// core top level, block wiring and memory ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_rdata,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata
);

    rv_pkg::word_t pc;
    rv_pkg::dec_t  dec;
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t jump_target;
    logic          jump_en;
    rv_pkg::word_t load_data;
    rv_pkg::word_t wb_data;
    logic          wb_en;

    assign imem_addr = pc;  // instruction read is combinational

    fetch_unit u_fetch_unit (
        .clk(clk), .reset(reset), .jump_en(jump_en), .jump_target(jump_target), .pc(pc)
    );

    inst_decoder u_inst_decoder (.inst(imem_rdata), .dec(dec));

    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_val), .rdata2(rs2_val),
        .wen(wb_en), .waddr(dec.rd), .wdata(wb_data)
    );

    exec_unit u_exec_unit (
        .dec(dec), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_result(alu_result), .jump_en(jump_en), .jump_target(jump_target)
    );

    load_store_unit u_load_store_unit (
        .reset(reset), .dec(dec), .addr(alu_result), .store_data(rs2_val),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .load_data(load_data)
    );

    writeback_unit u_writeback_unit (
        .dec(dec), .pc(pc), .alu_result(alu_result), .load_data(load_data),
        .wb_en(wb_en), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- hw/decode/inst_decoder.sv
////////////////////////////////////////////////////////////////////////////
// instruction decoder for fields, format, immediates and alu op
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  rv_pkg::word_t inst,
    output rv_pkg::dec_t  dec
);

    logic [6:0] funct7;

    assign funct7 = inst[31:25];

    // major opcode and format
    always_comb begin
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (inst[6:0])
            rv_pkg::op_reg:    dec.opcode = rv_pkg::op_reg;
            rv_pkg::op_imm:    dec.opcode = rv_pkg::op_imm;
            rv_pkg::op_load:   dec.opcode = rv_pkg::op_load;
            rv_pkg::op_store:  dec.opcode = rv_pkg::op_store;
            rv_pkg::op_branch: dec.opcode = rv_pkg::op_branch;
            rv_pkg::op_jal:    dec.opcode = rv_pkg::op_jal;
            rv_pkg::op_jalr:   dec.opcode = rv_pkg::op_jalr;
            rv_pkg::op_lui:    dec.opcode = rv_pkg::op_lui;
            rv_pkg::op_auipc:  dec.opcode = rv_pkg::op_auipc;
            default:           dec.opcode = rv_pkg::op_other;
        endcase

        case (dec.opcode)
            rv_pkg::op_reg:                                  dec.fmt = rv_pkg::fmt_r;
            rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_jalr: dec.fmt = rv_pkg::fmt_i;
            rv_pkg::op_store:                                dec.fmt = rv_pkg::fmt_s;
            rv_pkg::op_branch:                               dec.fmt = rv_pkg::fmt_b;
            rv_pkg::op_lui, rv_pkg::op_auipc:                dec.fmt = rv_pkg::fmt_u;
            rv_pkg::op_jal:                                  dec.fmt = rv_pkg::fmt_j;
            default:                                         dec.fmt = rv_pkg::fmt_none;
        endcase

        // immediates sign-extended from bit 31
        case (dec.fmt)
            rv_pkg::fmt_i: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::fmt_s: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::fmt_b: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::fmt_u: dec.imm = {inst[31:12], 12'b0};
            rv_pkg::fmt_j: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       dec.imm = '0;
        endcase

        // alu op for register and immediate arithmetic
        // everything else adds (addresses, targets, upper immediates)
        dec.alu_op = rv_pkg::alu_add;
        if (dec.opcode == rv_pkg::op_reg || dec.opcode == rv_pkg::op_imm) begin
            case (dec.funct3)
                3'b000: begin
                    if (dec.fmt == rv_pkg::fmt_r && funct7 == rv_pkg::funct7_sub) begin
                        dec.alu_op = rv_pkg::alu_sub;
                    end
                end
                3'b001:  dec.alu_op = rv_pkg::alu_sll;
                3'b010:  dec.alu_op = rv_pkg::alu_slt;
                3'b011:  dec.alu_op = rv_pkg::alu_sltu;
                3'b100:  dec.alu_op = rv_pkg::alu_xor;
                3'b101:  dec.alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110:  dec.alu_op = rv_pkg::alu_or;
                default: dec.alu_op = rv_pkg::alu_and;  // 3'b111
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/execute/alu.sv
////////////////////////////////////////////////////////////////////////////
// rv32i alu: add, sub, shifts, compares and logic ops
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $signed(a) >>> shamt;  // sign fill
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execute/exec_unit.sv
////////////////////////////////////////////////////////////////////////////
// execute stage: operand select, branch compare, jump target
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_val,
    input  rv_pkg::word_t rs2_val,
    output rv_pkg::word_t alu_result,
    output logic          jump_en,
    output rv_pkg::word_t jump_target
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic          taken;

    alu u_alu (.a(op_a), .b(op_b), .op(dec.alu_op), .result(alu_result));

    always_comb begin
        case (dec.opcode)
            rv_pkg::op_lui:                                       op_a = '0;
            rv_pkg::op_auipc, rv_pkg::op_jal, rv_pkg::op_branch:  op_a = pc;
            default:                                              op_a = rs1_val;  // R, I, S
        endcase
        op_b = (dec.fmt == rv_pkg::fmt_r) ? rs2_val : dec.imm;
    end

    // branch condition
    always_comb begin
        case (dec.funct3)
            rv_pkg::f3_beq:  taken = (rs1_val == rs2_val);
            rv_pkg::f3_bne:  taken = (rs1_val != rs2_val);
            rv_pkg::f3_blt:  taken = ($signed(rs1_val) <  $signed(rs2_val));
            rv_pkg::f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            rv_pkg::f3_bltu: taken = (rs1_val <  rs2_val);
            rv_pkg::f3_bgeu: taken = (rs1_val >= rs2_val);
            default:         taken = 1'b0;
        endcase
    end

    assign jump_en = (dec.opcode == rv_pkg::op_jal)
                  || (dec.opcode == rv_pkg::op_jalr)
                  || (dec.opcode == rv_pkg::op_branch && taken);

    // jalr drops bit 0 of the sum
    assign jump_target = (dec.opcode == rv_pkg::op_jalr)
                       ? {alu_result[rv_pkg::xlen-1:1], 1'b0}
                       : alu_result;

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// program counter and next-pc select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          jump_en,
    input  rv_pkg::word_t jump_target,
    output rv_pkg::word_t pc
);

    rv_pkg::word_t snpc;  // sequential pc
    rv_pkg::word_t dnpc;  // next pc actually taken

    assign snpc = pc + 32'd4;
    assign dnpc = jump_en ? jump_target : snpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
////////////////////////////////////////////////////////////////////////////
// data memory request and load extension
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic              reset,
    input  rv_pkg::dec_t      dec,
    input  rv_pkg::word_t     addr,
    input  rv_pkg::word_t     store_data,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     load_data
);

    logic is_store;

    assign is_store = (dec.opcode == rv_pkg::op_store);

    always_comb begin
        dmem_req.addr  = addr;
        dmem_req.wdata = store_data;  // no lane shift, accesses are aligned
        dmem_req.wen   = is_store && !reset;
        case (dec.funct3)
            rv_pkg::f3_byte: dmem_req.wmask = is_store ? 4'h1 : 4'h0;
            rv_pkg::f3_half: dmem_req.wmask = is_store ? 4'h3 : 4'h0;
            rv_pkg::f3_word: dmem_req.wmask = is_store ? 4'hf : 4'h0;
            default:         dmem_req.wmask = 4'h0;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            rv_pkg::f3_byte:   load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
            rv_pkg::f3_half:   load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
            rv_pkg::f3_byte_u: load_data = {24'b0, dmem_rdata[7:0]};
            rv_pkg::f3_half_u: load_data = {16'b0, dmem_rdata[15:0]};
            default:           load_data = dmem_rdata;  // lw
        endcase
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
////////////////////////////////////////////////////////////////////////////
// 32-entry register file, two read ports and one write port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata
);

    rv_pkg::word_t regs [rv_pkg::nregs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/writeback_unit.sv
////////////////////////////////////////////////////////////////////////////
// register write source and enable
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input  rv_pkg::dec_t  dec,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t alu_result,
    input  rv_pkg::word_t load_data,
    output logic          wb_en,
    output rv_pkg::word_t wb_data
);

    always_comb begin
        wb_en   = 1'b1;
        wb_data = alu_result;
        case (dec.opcode)
            rv_pkg::op_jal, rv_pkg::op_jalr: wb_data = pc + 32'd4;  // link
            rv_pkg::op_load:                 wb_data = load_data;
            rv_pkg::op_reg, rv_pkg::op_imm,
            rv_pkg::op_lui, rv_pkg::op_auipc: wb_data = alu_result;
            default:                         wb_en = 1'b0;  // branch, store, unknown
        endcase
    end

endmodule

`default_nettype wire

//--- tests/core_tb.sv
////////////////////////////////////////////////////////////////////////////
// core testbench with clock, reset, memory models, program and store tables
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int prog_len   = 79;
    localparam int n_stores   = 27;
    localparam int max_cycles = 2 * prog_len + 20;

    // hand-encoded program with word i at reset_pc + 4*i
    localparam rv_pkg::word_t prog [prog_len] = '{
        32'h0400_2E23,                                                // sw x0, held off by reset
        32'h0050_0093, 32'hFFD0_0113, 32'h0020_81B3, 32'h0030_2023,  // x1=5, x2=-3, add
        32'h4020_8233, 32'h0040_2223, 32'h0011_22B3, 32'h0050_2423,  // sub, slt
        32'h0011_3333, 32'h0060_2623, 32'h0020_C3B3, 32'h0070_2823,  // sltu, xor
        32'h0020_E433, 32'h0080_2A23, 32'h0020_F4B3, 32'h0090_2C23,  // or, and
        32'h0040_9513, 32'h00A0_2E23, 32'h4011_5593, 32'h02B0_2023,  // slli, srai
        32'h01C1_5613, 32'h02C0_2223, 32'h1234_56B7, 32'h02D0_2423,  // srli, lui
        32'h0000_1717, 32'h02E0_2623, 32'h0010_8463, 32'h0017_8793,  // auipc, taken set
        32'h0020_9463, 32'h0027_8793, 32'h0011_4463, 32'h0047_8793,
        32'h0020_D463, 32'h0087_8793, 32'h0020_E463, 32'h0107_8793,
        32'h0011_7463, 32'h0207_8793, 32'h0020_8463, 32'h0018_0813,  // not-taken set
        32'h0010_9463, 32'h0028_0813, 32'h0020_C463, 32'h0048_0813,
        32'h0011_5463, 32'h0088_0813, 32'h0011_6463, 32'h0108_0813,
        32'h0020_F463, 32'h0208_0813, 32'h02F0_2823, 32'h0300_2A23,
        32'h0080_08EF, 32'h0010_0913, 32'h0310_2C23, 32'h0118_89E7,  // jal, jalr
        32'h0010_0913, 32'h0330_2E23, 32'h0520_2023, 32'h89AB_DA37,
        32'hDEFA_0A13, 32'h1140_2023, 32'h1000_0A83, 32'h0550_2223,  // 89abcdef, lb
        32'h1000_4B03, 32'h0560_2423, 32'h1000_1B83, 32'h0570_2623,  // lbu, lh
        32'h1000_5C03, 32'h0580_2823, 32'h1000_2C83, 32'h0590_2A23,  // lhu, lw
        32'h1140_0223, 32'h1140_1423, 32'h07B0_0013, 32'h0010_8033,  // sb, sh, x0 writes
        32'h0400_2C23, 32'h0000_006F                                  // sw x0, spin
    };

    // expected stores in program order as addr, wdata, wmask, wen
    localparam rv_pkg::dmem_req_t exp_stores [n_stores] = '{
        '{32'h05C, 32'h0000_0000, 4'hf, 1'b1},
        '{32'h000, 32'h0000_0002, 4'hf, 1'b1}, '{32'h004, 32'h0000_0008, 4'hf, 1'b1},
        '{32'h008, 32'h0000_0001, 4'hf, 1'b1}, '{32'h00C, 32'h0000_0000, 4'hf, 1'b1},
        '{32'h010, 32'hFFFF_FFF8, 4'hf, 1'b1}, '{32'h014, 32'hFFFF_FFFD, 4'hf, 1'b1},
        '{32'h018, 32'h0000_0005, 4'hf, 1'b1}, '{32'h01C, 32'h0000_0050, 4'hf, 1'b1},
        '{32'h020, 32'hFFFF_FFFE, 4'hf, 1'b1}, '{32'h024, 32'h0000_000F, 4'hf, 1'b1},
        '{32'h028, 32'h1234_5000, 4'hf, 1'b1}, '{32'h02C, 32'h8000_1064, 4'hf, 1'b1},
        '{32'h030, 32'h0000_0000, 4'hf, 1'b1}, '{32'h034, 32'h0000_003F, 4'hf, 1'b1},
        '{32'h038, 32'h8000_00D8, 4'hf, 1'b1}, '{32'h03C, 32'h8000_00E4, 4'hf, 1'b1},
        '{32'h040, 32'h0000_0000, 4'hf, 1'b1}, '{32'h100, 32'h89AB_CDEF, 4'hf, 1'b1},
        '{32'h044, 32'hFFFF_FFEF, 4'hf, 1'b1}, '{32'h048, 32'h0000_00EF, 4'hf, 1'b1},
        '{32'h04C, 32'hFFFF_CDEF, 4'hf, 1'b1}, '{32'h050, 32'h0000_CDEF, 4'hf, 1'b1},
        '{32'h054, 32'h89AB_CDEF, 4'hf, 1'b1}, '{32'h104, 32'h89AB_CDEF, 4'h1, 1'b1},
        '{32'h108, 32'h89AB_CDEF, 4'h3, 1'b1}, '{32'h058, 32'h0000_0000, 4'hf, 1'b1}
    };

    logic              clk = 1'b0;
    logic              reset;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_rdata;
    rv_pkg::dmem_req_t dmem_req;
    rv_pkg::word_t     dmem_rdata;
    rv_pkg::word_t     imem_off;
    rv_pkg::word_t     dmem [256];
    int                checks = 0;
    int                errors = 0;
    int                cycles = 0;

    core_top u_core_top (
        .clk(clk), .reset(reset),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    always #50 clk = ~clk;

    // instruction memory returns nop outside the program
    assign imem_off   = imem_addr - rv_pkg::reset_pc;
    assign imem_rdata = (imem_off < rv_pkg::word_t'(prog_len * 4)) ? prog[imem_off[8:2]]
                                                                   : 32'h0000_0013;

    assign dmem_rdata = dmem[dmem_req.addr[9:2]];  // same-cycle read

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    dmem[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: program did not finish within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    initial begin
        reset = 1'b1;
        for (int k = 0; k < 256; k++) begin
            dmem[k] = '0;
        end
        repeat (3) begin
            @(negedge clk);
            if (dmem_req.wen) begin
                errors++;
                $display("a store request was raised while reset was high");
            end
        end
        @(posedge clk);
        reset <= 1'b0;  // fourth edge under reset

        @(negedge clk);
        check_word("imem_addr", imem_addr, rv_pkg::reset_pc);

        for (int i = 0; i < n_stores; i++) begin
            while (!dmem_req.wen) @(negedge clk);
            check_word("dmem_req.addr", dmem_req.addr, exp_stores[i].addr);
            check_word("dmem_req.wdata", dmem_req.wdata, exp_stores[i].wdata);
            check_mask("dmem_req.wmask", dmem_req.wmask, exp_stores[i].wmask);
            @(negedge clk);
        end

        // core now spins on its last jal
        repeat (4) begin
            if (dmem_req.wen) begin
                errors++;
                $display("an unexpected store went to address %h", dmem_req.addr);
            end
            @(negedge clk);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/core_tb_assert.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the core memory ports, bound to core_top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_tb_assert (
    input logic              clk,
    input logic              reset,
    input rv_pkg::word_t     imem_addr,
    input rv_pkg::dmem_req_t dmem_req
);

    // memory must never see a store under reset
    no_store_in_reset: assert property (@(posedge clk) reset |-> !dmem_req.wen)
        else $error("store request while reset is high");

    fetch_aligned: assert property (
        @(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00
    ) else $error("imem_addr %h is not word aligned", imem_addr);

    // sb, sh and sw lane patterns only
    legal_mask: assert property (
        @(posedge clk) dmem_req.wen |->
            (dmem_req.wmask == 4'h1 || dmem_req.wmask == 4'h3 || dmem_req.wmask == 4'hf)
    ) else $error("illegal store mask %h", dmem_req.wmask);

endmodule

bind core_top core_tb_assert u_core_tb_assert (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .dmem_req(dmem_req)
);

`default_nettype wire

//--- vlog.f
common/rv_pkg.sv
hw/fetch_unit.sv
hw/decode/inst_decoder.sv
hw/reg_file.sv
hw/execute/alu.sv
hw/execute/exec_unit.sv
hw/load_store_unit.sv
hw/writeback_unit.sv
hw/core_top.sv
tests/core_tb_assert.sv
tests/core_tb.sv
